// ==== filelist.f ====
+incdir+include
src/antic_pkg.sv
src/anticRegs.sv
src/dlCounter.sv
src/dlDecode.sv
src/dlFetch.sv
src/anticTop.sv
verif/antic_assert.sv
verif/tb_antic.sv

// ==== include/antic_macros.svh ====
////////////////////////////////////////////////////////////////////////////
// ANTIC register map and constants
////////////////////////////////////////////////////////////////////////////
`ifndef ANTIC_MACROS_SVH
`define ANTIC_MACROS_SVH

// Register offsets within $D4xx
`define REG_DMACTL      4'h0
`define REG_CHACTL      4'h1
`define REG_DLISTL      4'h2
`define REG_DLISTH      4'h3
`define REG_NMIEN       4'hE

// OS shadow copies of the display-list pointer
`define SHADOW_DLISTL   16'h0230
`define SHADOW_DLISTH   16'h0231

// Control bits
`define DMACTL_DL_BIT   5       // Display-list DMA enable
`define NMIEN_DLI_BIT   7       // DLI enable

// Counter bits that take part in the increment
`define DL_WRAP_BITS    10

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the ANTIC display-list testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
        --top-module tb_antic -Mdir obj_dir
if [ $? -ne 0 ]; then
        echo "Verilator build failed"
        exit 1
fi

./obj_dir/Vtb_antic > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
        echo "Simulation exited with status $status"
        exit 1
fi

if grep -qx "All checks passed" "$LOG"; then
        exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== src/anticRegs.sv ====
////////////////////////////////////////////////////////////////////////////
// ANTIC CPU register writes
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

`include "antic_macros.svh"

module anticRegs (
        input  logic                    phi2,
        input  logic                    RST,
        input  logic                    regWrite,
        input  antic_pkg::regWrite_t    regBus,
        output logic                    dlEnable,
        output logic                    dliEnable,
        output logic [7:0]              chactl,
        output logic                    ptrLoadLo,
        output logic                    ptrLoadHi,
        output logic [7:0]              ptrData
);

        logic [7:0] dmactl;
        logic [7:0] nmien;

        // Control registers, both off after reset
        always_ff @(posedge phi2) begin
                if (RST) begin
                        dmactl <= 8'h00;
                        nmien  <= 8'h00;
                end else if (regWrite) begin
                        case (regBus.addr)
                                `REG_DMACTL: dmactl <= regBus.data;
                                `REG_NMIEN:  nmien  <= regBus.data;
                                default: ;
                        endcase
                end
        end

        // Character control, passed on to the playfield side
        always_ff @(posedge phi2) begin
                if (regWrite && regBus.addr == `REG_CHACTL)
                        chactl <= regBus.data;
        end

        assign dlEnable  = dmactl[`DMACTL_DL_BIT];
        assign dliEnable = nmien[`NMIEN_DLI_BIT];

        // Pointer bytes live in the counter, so only strobe them here
        assign ptrLoadLo = regWrite && (regBus.addr == `REG_DLISTL);
        assign ptrLoadHi = regWrite && (regBus.addr == `REG_DLISTH);
        assign ptrData   = regBus.data;

endmodule

// ==== src/anticTop.sv ====
////////////////////////////////////////////////////////////////////////////
// ANTIC display-list DMA top
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module anticTop (
        input  logic                    phi2,
        input  logic                    RST,
        input  logic                    regWrite,
        input  antic_pkg::regWrite_t    regBus,
        input  logic [7:0]              dataIn,
        input  logic                    lineDone,
        input  logic                    vblank,
        output logic [15:0]             address,
        output logic                    halt,
        output logic                    instrValid,
        output antic_pkg::dlInstr_t     instr,
        output logic                    nmi,
        output logic [7:0]              chactl
);

        logic           dlEnable;
        logic           dliEnable;
        logic           ptrLoadLo;
        logic           ptrLoadHi;
        logic [7:0]     ptrData;
        logic           fetchLoadLo;
        logic           fetchLoadHi;
        logic [7:0]     fetchData;
        logic           incr;
        logic           loadFull;
        logic [15:0]    fullValue;
        logic [15:0]    pointer;        // DLISTH:DLISTL

        anticRegs u_anticRegs (
                .phi2           (phi2),
                .RST            (RST),
                .regWrite       (regWrite),
                .regBus         (regBus),
                .dlEnable       (dlEnable),
                .dliEnable      (dliEnable),
                .chactl         (chactl),
                .ptrLoadLo      (ptrLoadLo),
                .ptrLoadHi      (ptrLoadHi),
                .ptrData        (ptrData)
        );

        dlCounter u_dlCounter (
                .phi2           (phi2),
                .ptrLoadLo      (ptrLoadLo),
                .ptrLoadHi      (ptrLoadHi),
                .ptrData        (ptrData),
                .fetchLoadLo    (fetchLoadLo),
                .fetchLoadHi    (fetchLoadHi),
                .loadFull       (loadFull),
                .fullValue      (fullValue),
                .fetchData      (fetchData),
                .incr           (incr),
                .pointer        (pointer)
        );

        dlFetch u_dlFetch (
                .phi2           (phi2),
                .RST            (RST),
                .dlEnable       (dlEnable),
                .dliEnable      (dliEnable),
                .dataIn         (dataIn),
                .pointer        (pointer),
                .lineDone       (lineDone),
                .vblank         (vblank),
                .halt           (halt),
                .address        (address),
                .fetchLoadLo    (fetchLoadLo),
                .fetchLoadHi    (fetchLoadHi),
                .fetchData      (fetchData),
                .incr           (incr),
                .loadFull       (loadFull),
                .fullValue      (fullValue),
                .instrValid     (instrValid),
                .instr          (instr),
                .nmi            (nmi)
        );

endmodule

// ==== src/antic_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// ANTIC display-list types
////////////////////////////////////////////////////////////////////////////
package antic_pkg;

        // Fetch engine states
        typedef enum logic [2:0] {
                shadowLo,       // Read $0230
                shadowHi,       // Read $0231
                fetchInstr,
                fetchOpLo,
                fetchOpHi,
                emit,           // instrValid cycle
                waitLine,       // Line engine busy
                waitVblank
        } fetchState_e;

        // Instruction classes
        typedef enum logic [1:0] {
                blank,
                modeLine,
                jump,
                jumpVblank
        } dlOpcode_e;

        // Decoded display-list instruction
        typedef struct packed {
                dlOpcode_e      opcode;
                logic [3:0]     mode;           // Blank lines minus one for blank
                logic           dli;
                logic           lms;
                logic           hscrol;
                logic           vscrol;
                logic [15:0]    operand;        // Screen address or jump target
        } dlInstr_t;

        // CPU register write
        typedef struct packed {
                logic [3:0]     addr;
                logic [7:0]     data;
        } regWrite_t;

endpackage

// ==== src/dlCounter.sv ====
////////////////////////////////////////////////////////////////////////////
// Display-list counter
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

`include "antic_macros.svh"

module dlCounter (
        input  logic            phi2,
        input  logic            ptrLoadLo,
        input  logic            ptrLoadHi,
        input  logic [7:0]      ptrData,
        input  logic            fetchLoadLo,
        input  logic            fetchLoadHi,
        input  logic            loadFull,
        input  logic [15:0]     fullValue,
        input  logic [7:0]      fetchData,
        input  logic            incr,
        output logic [15:0]     pointer
);

        logic                           byteLoad;
        logic [`DL_WRAP_BITS-1:0]       nextLow;

        assign byteLoad = ptrLoadLo || ptrLoadHi || fetchLoadLo || fetchLoadHi;

        // Upper bits never carry, list wraps inside its 1K block
        assign nextLow = pointer[`DL_WRAP_BITS-1:0] + `DL_WRAP_BITS'(1);

        always_ff @(posedge phi2) begin
                if (loadFull) begin
                        pointer <= fullValue;           // Jump target
                end else if (byteLoad) begin
                        if (fetchLoadLo)
                                pointer[7:0] <= fetchData;
                        else if (ptrLoadLo)
                                pointer[7:0] <= ptrData;
                        if (fetchLoadHi)
                                pointer[15:8] <= fetchData;
                        else if (ptrLoadHi)
                                pointer[15:8] <= ptrData;
                end else if (incr) begin
                        pointer[`DL_WRAP_BITS-1:0] <= nextLow;
                end
        end

endmodule

// ==== src/dlDecode.sv ====
////////////////////////////////////////////////////////////////////////////
// Display-list instruction decode
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module dlDecode (
        input  logic [7:0]              instrByte,
        output antic_pkg::dlInstr_t     decoded,
        output logic [1:0]              operandCount
);
        import antic_pkg::*;

        logic [3:0] lowNibble;

        assign lowNibble = instrByte[3:0];

        always_comb begin
                decoded         = '0;
                decoded.dli     = instrByte[7];         // Same bit for every class
                decoded.mode    = lowNibble;
                operandCount    = 2'd0;

                case (lowNibble)
                        4'h0: begin
                                // Blank lines, count minus one in bits 6:4
                                decoded.opcode = blank;
                                decoded.mode   = {1'b0, instrByte[6:4]};
                        end
                        4'h1: begin
                                // Bit 6 picks JVB over JMP
                                if (instrByte[6])
                                        decoded.opcode = jumpVblank;
                                else
                                        decoded.opcode = jump;
                                operandCount = 2'd2;    // Target address
                        end
                        default: begin
                                decoded.opcode = modeLine;
                                decoded.lms    = instrByte[6];
                                decoded.vscrol = instrByte[5];
                                decoded.hscrol = instrByte[4];
                                if (instrByte[6])
                                        operandCount = 2'd2;    // New screen address
                        end
                endcase
        end

endmodule

// ==== src/dlFetch.sv ====
////////////////////////////////////////////////////////////////////////////
// Display-list fetch engine
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

`include "antic_macros.svh"

module dlFetch (
        input  logic                    phi2,
        input  logic                    RST,
        input  logic                    dlEnable,
        input  logic                    dliEnable,
        input  logic [7:0]              dataIn,
        input  logic [15:0]             pointer,
        input  logic                    lineDone,
        input  logic                    vblank,
        output logic                    halt,
        output logic [15:0]             address,
        output logic                    fetchLoadLo,
        output logic                    fetchLoadHi,
        output logic [7:0]              fetchData,
        output logic                    incr,
        output logic                    loadFull,
        output logic [15:0]             fullValue,
        output logic                    instrValid,
        output antic_pkg::dlInstr_t     instr,
        output logic                    nmi
);
        import antic_pkg::*;

        fetchState_e    state;
        fetchState_e    nextState;
        logic           started;        // Low for the cycle right after reset
        dlInstr_t       decoded;
        logic [1:0]     operandCount;
        logic           instrRead;

        dlDecode u_dlDecode (
                .instrByte      (dataIn),
                .decoded        (decoded),
                .operandCount   (operandCount)
        );

        assign instrRead = (state == fetchInstr) && dlEnable;

        // Bus request per state
        always_comb begin
                case (state)
                        shadowLo:               halt = started;
                        shadowHi:               halt = 1'b1;
                        fetchInstr:             halt = dlEnable;
                        fetchOpLo, fetchOpHi:   halt = 1'b1;
                        default:                halt = 1'b0;
                endcase
        end

        always_comb begin
                case (state)
                        shadowLo: address = `SHADOW_DLISTL;
                        shadowHi: address = `SHADOW_DLISTH;
                        default:  address = pointer;
                endcase
        end

        // Counter control
        assign fetchLoadLo = (state == shadowLo) && started;
        assign fetchLoadHi = (state == shadowHi);
        assign fetchData   = dataIn;
        assign incr        = instrRead || state == fetchOpLo || state == fetchOpHi;
        assign loadFull    = (state == emit) && (instr.opcode == jump ||
                             instr.opcode == jumpVblank);
        assign fullValue   = instr.operand;

        assign instrValid  = (state == emit);
        assign nmi         = instrValid && instr.dli && dliEnable;

        always_comb begin
                nextState = state;
                case (state)
                        shadowLo: begin
                                if (started)
                                        nextState = shadowHi;
                        end
                        shadowHi: nextState = fetchInstr;
                        fetchInstr: begin
                                if (dlEnable)
                                        nextState = (operandCount == 2'd2) ? fetchOpLo : emit;
                        end
                        fetchOpLo: nextState = fetchOpHi;
                        fetchOpHi: nextState = emit;
                        emit: begin
                                case (instr.opcode)
                                        jump:           nextState = fetchInstr;
                                        jumpVblank:     nextState = waitVblank;
                                        default:        nextState = waitLine;
                                endcase
                        end
                        waitLine: begin
                                if (lineDone)
                                        nextState = fetchInstr;
                        end
                        waitVblank: begin
                                if (vblank)
                                        nextState = fetchInstr;
                        end
                        default: nextState = shadowLo;
                endcase
        end

        always_ff @(posedge phi2) begin
                if (RST) begin
                        state   <= shadowLo;
                        started <= 1'b0;
                end else begin
                        state   <= nextState;
                        started <= 1'b1;
                end
        end

        // Instruction record, operand bytes arrive low then high
        always_ff @(posedge phi2) begin
                if (instrRead)
                        instr <= decoded;
                if (state == fetchOpLo)
                        instr.operand[7:0] <= dataIn;
                if (state == fetchOpHi)
                        instr.operand[15:8] <= dataIn;
        end

endmodule

// ==== verif/antic_assert.sv ====
////////////////////////////////////////////////////////////////////////////
// Bus and strobe checks
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module anticAssert (
        input  logic    phi2,
        input  logic    RST,
        input  logic    halt,
        input  logic    instrValid,
        input  logic    nmi
);

        int failures = 0;               // Failed properties so far

        // State is still unknown on the first edge, so that edge is skipped
        haltQuietInReset: assert property (@(posedge phi2) RST && $past(RST) |-> !halt)
                else begin
                        failures++;
                        $error("halt raised while RST is high");
                end

        validIsPulse: assert property (@(posedge phi2) disable iff (RST)
                instrValid |=> !instrValid)
                else begin
                        failures++;
                        $error("instrValid held longer than one cycle");
                end

        nmiIsPulse: assert property (@(posedge phi2) disable iff (RST) nmi |=> !nmi)
                else begin
                        failures++;
                        $error("nmi held longer than one cycle");
                end

        nmiWithValid: assert property (@(posedge phi2) disable iff (RST) nmi |-> instrValid)
                else begin
                        failures++;
                        $error("nmi raised without instrValid");
                end

endmodule

bind anticTop anticAssert u_anticAssert (
        .phi2           (phi2),
        .RST            (RST),
        .halt           (halt),
        .instrValid     (instrValid),
        .nmi            (nmi)
);

// ==== verif/tb_antic.sv ====
////////////////////////////////////////////////////////////////////////////
// ANTIC display-list testbench
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

`include "antic_macros.svh"

module tb_antic;
        import antic_pkg::*;

        localparam int TIMEOUT = 64;            // Cycles allowed per wait

        logic           phi2 = 1'b0;
        logic           RST;
        logic           regWrite;
        regWrite_t      regBus;
        logic [7:0]     dataIn = 8'h00;
        logic           lineDone;
        logic           vblank;
        logic [15:0]    address;
        logic           halt;
        logic           instrValid;
        dlInstr_t       instr;
        logic           nmi;
        logic [7:0]     chactl;

        logic [7:0]     mem [0:65535];
        logic [15:0]    haltLog [$];            // Every halted bus address
        logic [31:0]    lfsr = 32'h6353;
        logic [15:0]    nextAddr;               // Where the list continues
        dlInstr_t       got;
        logic           gotNmi;
        int             errors = 0;
        int             timeouts = 0;

        always #20 phi2 = ~phi2;

        anticTop u_anticTop (
                .phi2           (phi2),
                .RST            (RST),
                .regWrite       (regWrite),
                .regBus         (regBus),
                .dataIn         (dataIn),
                .lineDone       (lineDone),
                .vblank         (vblank),
                .address        (address),
                .halt           (halt),
                .instrValid     (instrValid),
                .instr          (instr),
                .nmi            (nmi),
                .chactl         (chactl)
        );

        // Memory answers halted reads half a cycle early
        always @(negedge phi2) begin
                if (halt) begin
                        dataIn <= mem[address];
                        haltLog.push_back(address);
                end
        end

        function automatic logic [31:0] lfsrNext(input logic [31:0] s);
                return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32,22,2,1
        endfunction

        task automatic drawByte(output logic [7:0] b);
                b = 8'h00;
                for (int i = 0; i < 8; i++) begin
                        lfsr = lfsrNext(lfsr);
                        b = {b[6:0], lfsr[0]};
                end
        endtask

        task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                        input string what);
                if (timeouts == 0 && actual !== expected) begin
                        errors++;
                        $display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, what,
                                actual, expected);
                end
        endtask

        task automatic writeReg(input logic [3:0] addr, input logic [7:0] data);
                @(negedge phi2);
                regWrite = 1'b1;
                regBus.addr = addr;
                regBus.data = data;
                @(negedge phi2);
                regWrite = 1'b0;
        endtask

        task automatic checkIdle(input int cycles, input string what);
                repeat (cycles) begin
                        @(negedge phi2);
                        compare(halt, 0, what);
                end
        endtask

        // Called on a falling edge and returns on the edge of the fetch
        task automatic waitFetch(input logic [15:0] at);
                int n = 0;
                while (!halt && n < TIMEOUT && timeouts == 0) begin
                        n++;
                        @(negedge phi2);
                end
                if (n == TIMEOUT) begin
                        timeouts++;
                        $display("Timed out at %0t ns waiting for a fetch from %h", $time, at);
                end
                compare(address, at, "fetch address");
        endtask

        task automatic waitInstr();
                int n = 0;
                @(negedge phi2);
                while (!instrValid && n < TIMEOUT && timeouts == 0) begin
                        n++;
                        @(negedge phi2);
                end
                if (n == TIMEOUT) begin
                        timeouts++;
                        $display("Timed out at %0t ns waiting for instrValid", $time);
                end
                got = instr;
                gotNmi = nmi;
        endtask

        // Line engine finishes a few cycles after the instruction
        task automatic releaseLine();
                checkIdle(3, "halt before lineDone");
                lineDone = 1'b1;
                @(negedge phi2);
                lineDone = 1'b0;
        endtask

        task automatic nextInstr(input logic [15:0] at);
                releaseLine();
                waitFetch(at);
                waitInstr();
        endtask

        task automatic testReset();
                mem[`SHADOW_DLISTL] = 8'h40;
                mem[`SHADOW_DLISTH] = 8'h20;
                mem[16'h2040] = 8'h70;                  // Eight blank lines
                checkIdle(5, "halt during reset");
                // Writes under reset are dropped, so this one rides the release edge
                RST = 1'b0;
                regWrite = 1'b1;
                regBus.addr = `REG_DMACTL;
                regBus.data = 8'h20;
                @(negedge phi2);
                regWrite = 1'b0;
                compare(halt, 1, "halt in the first cycle after reset");
                compare(address, `SHADOW_DLISTL, "address in the first cycle after reset");
                waitInstr();
                compare(haltLog.size(), 3, "halted reads up to the first instruction");
                compare(haltLog[0], `SHADOW_DLISTL, "first halted address");
                compare(haltLog[1], `SHADOW_DLISTH, "second halted address");
                compare(haltLog[2], 16'h2040, "first instruction address");
                compare(got.opcode, blank, "first opcode");
                compare(got.mode, 4'h7, "first blank count");
                nextAddr = 16'h2041;
        endtask

        task automatic testDecode();
                logic [7:0] b;
                logic       isBlank;
                for (int i = 0; i < 8; i++) begin
                        drawByte(b);
                        if (b[3:0] == 4'h1)
                                b[3:0] = 4'h0;          // Jumps come later
                        isBlank = (b[3:0] == 4'h0);
                        if (!isBlank)
                                b[6] = 1'b0;            // No LMS
                        mem[nextAddr] = b;
                        nextInstr(nextAddr);
                        compare(got.opcode, isBlank ? blank : modeLine, "random opcode");
                        compare(got.mode, isBlank ? {1'b0, b[6:4]} : b[3:0], "random mode");
                        compare(got.dli, b[7], "random dli");
                        compare(got.lms, 0, "random lms");
                        compare(got.vscrol, !isBlank && b[5], "random vscrol");
                        compare(got.hscrol, !isBlank && b[4], "random hscrol");
                        compare(gotNmi, 0, "nmi with NMIEN clear");
                        nextAddr++;
                end
        endtask

        task automatic testLms();
                mem[nextAddr] = 8'h4D;                  // Mode D with LMS $1234
                mem[nextAddr + 1] = 8'h34;
                mem[nextAddr + 2] = 8'h12;
                mem[nextAddr + 3] = 8'h00;
                nextInstr(nextAddr);
                compare(got.opcode, modeLine, "LMS opcode");
                compare(got.lms, 1, "LMS flag");
                compare(got.mode, 4'hD, "LMS mode");
                compare(got.operand, 16'h1234, "LMS operand");
                compare(haltLog[haltLog.size() - 2], nextAddr + 1, "operand low address");
                compare(haltLog[haltLog.size() - 1], nextAddr + 2, "operand high address");
                nextInstr(nextAddr + 3);
                compare(got.opcode, blank, "instruction after LMS");
                nextAddr = nextAddr + 4;
        endtask

        task automatic testJumps();
                mem[nextAddr] = 8'h01;                  // JMP $3000
                mem[nextAddr + 1] = 8'h00;
                mem[nextAddr + 2] = 8'h30;
                mem[16'h3000] = 8'h10;
                mem[16'h3001] = 8'h41;                  // JVB $2100
                mem[16'h3002] = 8'h00;
                mem[16'h3003] = 8'h21;
                mem[16'h2100] = 8'h20;
                nextInstr(nextAddr);
                compare(got.opcode, jump, "JMP opcode");
                compare(got.operand, 16'h3000, "JMP target");
                @(negedge phi2);
                compare(halt, 1, "halt right after JMP");
                waitFetch(16'h3000);
                waitInstr();
                compare(got.mode, 4'h1, "blank count at JMP target");
                nextInstr(16'h3001);
                compare(got.opcode, jumpVblank, "JVB opcode");
                compare(got.operand, 16'h2100, "JVB target");
                checkIdle(4, "halt while waiting for vblank");
                lineDone = 1'b1;                        // Has no effect on JVB
                @(negedge phi2);
                lineDone = 1'b0;
                checkIdle(4, "halt after lineDone during JVB");
                vblank = 1'b1;
                @(negedge phi2);
                vblank = 1'b0;
                waitFetch(16'h2100);
                waitInstr();
                compare(got.mode, 4'h2, "blank count after JVB");
                nextAddr = 16'h2101;
        endtask

        task automatic testDli();
                mem[nextAddr] = 8'h82;
                mem[nextAddr + 1] = 8'h82;
                writeReg(`REG_NMIEN, 8'h80);
                nextInstr(nextAddr);
                compare(got.dli, 1, "dli flag");
                compare(gotNmi, 1, "nmi with NMIEN set");
                writeReg(`REG_NMIEN, 8'h00);
                nextInstr(nextAddr + 1);
                compare(got.dli, 1, "dli flag");
                compare(gotNmi, 0, "nmi with NMIEN clear");
        endtask

        task automatic testChactl();
                writeReg(`REG_CHACTL, 8'h06);
                compare(chactl, 8'h06, "CHACTL after its write");
                writeReg(`REG_NMIEN, 8'h00);
                compare(chactl, 8'h06, "CHACTL after an NMIEN write");
        endtask

        task automatic testWrap();
                mem[16'h13FE] = 8'h02;
                mem[16'h13FF] = 8'h02;
                mem[16'h1000] = 8'h0F;
                mem[16'h2500] = 8'h03;
                writeReg(`REG_DLISTL, 8'hFE);
                writeReg(`REG_DLISTH, 8'h13);
                nextInstr(16'h13FE);
                nextInstr(16'h13FF);
                nextInstr(16'h1000);                    // Stays in the 1K block
                compare(got.mode, 4'hF, "mode after wrap");
                writeReg(`REG_DMACTL, 8'h00);
                writeReg(`REG_DLISTL, 8'h00);
                writeReg(`REG_DLISTH, 8'h25);
                releaseLine();
                checkIdle(8, "halt with display-list DMA off");
                writeReg(`REG_DMACTL, 8'h22);
                waitFetch(16'h2500);
                waitInstr();
                compare(got.mode, 4'h3, "mode after redirect");
        endtask

        initial begin
                RST = 1'b1;
                regWrite = 1'b0;
                regBus = '0;
                lineDone = 1'b0;
                vblank = 1'b0;
                for (int a = 0; a < 65536; a++)
                        mem[a] = a[7:0] ^ a[15:8];
                testReset();
                testDecode();
                testLms();
                testJumps();
                testDli();
                testChactl();
                testWrap();
                $display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                        errors, timeouts, u_anticTop.u_anticAssert.failures);
                if (errors == 0 && timeouts == 0 && u_anticTop.u_anticAssert.failures == 0)
                        $display("All checks passed");
                else
                        $display("Checks failed");
                $finish;
        end

endmodule
